// ==== rcfg_avmm_mstr.sv ====
//==================================================
// DPRIO master FSM for one transceiver lane
// Full writes, masked RMW, logical refclk and CGB
// selects and calibration handover
//==================================================
`timescale 1ns/1ps

module rcfg_avmm_mstr (
  input  logic       clk,
  input  logic       reset,
  // Command issuer
  input  logic [9:0] ctrl_addr,
  input  logic [7:0] ctrl_writedata,
  input  logic [7:0] ctrl_datamask,
  input  logic       ctrl_write,
  input  logic       ctrl_rmw,
  input  logic       refclk_req,
  input  logic       cgb_req,
  input  logic       cal_req,
  input  logic       refclk_sel,      // 0 scratch 0, 1 scratch 1
  input  logic       cgb_sel,         // 0 low nibble, 1 high nibble
  input  logic       cal_sel,         // 1 request cal, 0 release bus
  output logic       ctrl_busy,
  // DPRIO bus
  output logic       xcvr_rcfg_write,
  output logic       xcvr_rcfg_read,
  output logic [9:0] xcvr_rcfg_address,
  output logic [7:0] xcvr_rcfg_wrdata,
  input  logic [7:0] xcvr_rcfg_rddata,
  input  logic       xcvr_rcfg_wtrqst
);
  import xcvr_rcfg_pkg::*;

  //==================================================
  // Control FSM
  //==================================================
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_WR,    // Write transfer on the bus
    CTRL_RD     // Read transfer on the bus
  } ctrl_state_e;

  ctrl_state_e ctrl_state;
  ctrl_state_e ctrl_next_state;
  logic        wr_done;   // Write accepted by the lane
  logic        rd_done;   // Read data valid

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ctrl_state <= CTRL_IDLE;
    else
      ctrl_state <= ctrl_next_state;
  end

  always_comb begin
    case (ctrl_state)
      CTRL_IDLE: begin
        if (ctrl_write | cal_req)
          ctrl_next_state = CTRL_WR;
        else if (ctrl_rmw | refclk_req | cgb_req)
          ctrl_next_state = CTRL_RD;   // Read first, write back after
        else
          ctrl_next_state = CTRL_IDLE;
      end
      CTRL_WR: ctrl_next_state = xcvr_rcfg_wtrqst ? CTRL_WR : CTRL_IDLE;
      CTRL_RD: ctrl_next_state = xcvr_rcfg_wtrqst ? CTRL_RD : CTRL_WR;
      default: ctrl_next_state = CTRL_IDLE;
    endcase
  end

  assign ctrl_busy = (ctrl_next_state != CTRL_IDLE);
  assign wr_done   = (ctrl_state == CTRL_WR) & ~xcvr_rcfg_wtrqst;
  assign rd_done   = (ctrl_state == CTRL_RD) & ~xcvr_rcfg_wtrqst;

  //==================================================
  // Operation flags, set by request, cleared by write
  //==================================================
  logic refclk_active;
  logic cgb_active;
  logic rmw_active;
  logic cal_active;
  logic refclk_op;        // Request cycle or later
  logic cgb_op;
  logic cal_op;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      refclk_active <= 1'b0;
      cgb_active    <= 1'b0;
      rmw_active    <= 1'b0;
      cal_active    <= 1'b0;
    end else if (wr_done) begin
      refclk_active <= 1'b0;
      cgb_active    <= 1'b0;
      rmw_active    <= 1'b0;
      cal_active    <= 1'b0;
    end else begin
      refclk_active <= refclk_active | refclk_req;
      cgb_active    <= cgb_active | cgb_req;
      rmw_active    <= rmw_active | ctrl_rmw;
      cal_active    <= cal_active | cal_req;
    end
  end

  assign refclk_op = refclk_req | refclk_active;
  assign cgb_op    = cgb_req | cgb_active;
  assign cal_op    = cal_req | cal_active;

  //==================================================
  // DPRIO bus outputs
  //==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      xcvr_rcfg_read  <= 1'b0;
      xcvr_rcfg_write <= 1'b0;
    end else begin
      xcvr_rcfg_read  <= (ctrl_next_state == CTRL_RD);
      xcvr_rcfg_write <= (ctrl_next_state == CTRL_WR);
    end
  end

  // Address per phase, held while the lane waits
  always_ff @(posedge clk) begin
    if (ctrl_next_state == CTRL_RD) begin
      if (refclk_op)
        xcvr_rcfg_address <= refclk_sel ? ADDR_REFCLK1_SCR : ADDR_REFCLK0_SCR;
      else if (cgb_op)
        xcvr_rcfg_address <= ADDR_CGB_SCR;
      else
        xcvr_rcfg_address <= ctrl_addr;         // RMW source
    end else if (ctrl_next_state == CTRL_WR) begin
      if (refclk_active)
        xcvr_rcfg_address <= ADDR_REFCLK_MUX;
      else if (cgb_active)
        xcvr_rcfg_address <= ADDR_CGB_MUX;
      else if (cal_op)
        xcvr_rcfg_address <= cal_sel ? ADDR_CAL_REQ : ADDR_ARB;
      else
        xcvr_rcfg_address <= ctrl_addr;         // Plain write or RMW target
    end
  end

  //==================================================
  // Write data
  //==================================================
  logic [3:0] cgb_nib;     // Chosen logical PLL nibble
  logic [7:0] cgb_data;
  logic [7:0] rmw_data;

  // Nibble bits 2:0 select x1 clock, bit 3 selects xN
  assign cgb_nib  = cgb_sel ? xcvr_rcfg_rddata[7:4] : xcvr_rcfg_rddata[3:0];
  assign cgb_data = {~cgb_nib[3], cgb_nib[1:0], cgb_nib[3], cgb_nib};
  assign rmw_data = (xcvr_rcfg_rddata & ~ctrl_datamask) |
                    (ctrl_writedata   &  ctrl_datamask);

  always_ff @(posedge clk) begin
    if (ctrl_write)
      xcvr_rcfg_wrdata <= ctrl_writedata;
    else if (cal_req)
      xcvr_rcfg_wrdata <= cal_sel ? CAL_REQ_WORD : ARB_RELEASE_WORD;
    else if (rd_done) begin                     // Build write-back from read byte
      if (refclk_active)
        xcvr_rcfg_wrdata <= xcvr_rcfg_rddata;   // Scratch copied unchanged
      else if (cgb_active)
        xcvr_rcfg_wrdata <= cgb_data;
      else if (rmw_active)
        xcvr_rcfg_wrdata <= rmw_data;
    end
  end

endmodule

// ==== rcfg_axil_regs.sv ====
//==================================================
// AXI4-Lite host registers
// CMD launches a command unless busy or illegal,
// STATUS shows busy, DONE counts finished commands
//==================================================
`timescale 1ns/1ps

module rcfg_axil_regs (
  input  logic                     clk,
  input  logic                     reset,
  // AXI4-Lite write channels
  input  logic [3:0]               awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic                     bvalid,
  output logic [1:0]               bresp,
  input  logic                     bready,
  // AXI4-Lite read channels
  input  logic [3:0]               araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic                     rvalid,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  input  logic                     rready,
  // Command issuer
  output logic                     cmd_valid,
  output xcvr_rcfg_pkg::rcfg_cmd_t cmd_word,
  input  logic                     issue_busy,
  input  logic                     cmd_done
);
  import xcvr_rcfg_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic        wr_rdy;     // Shared awready and wready
  logic        wr_hs;      // Write address and data accepted
  logic        cmd_hit;    // Write targets CMD
  logic        cmd_ok;     // Command may start
  logic        launch;
  rcfg_cmd_t   wr_cmd;     // Write data seen as a command
  logic [15:0] done_cnt;   // Wraps
  logic [31:0] rd_mux;

  assign awready = wr_rdy;
  assign wready  = wr_rdy;
  assign wr_hs   = wr_rdy & awvalid & wvalid;
  assign wr_cmd  = wdata;
  assign cmd_hit = (awaddr == REG_CMD);

  // Busy engine, partial strobe or opcode 5 to 7 are refused
  assign cmd_ok  = ~issue_busy & (wstrb == 4'hF) & (wr_cmd.data_cmd.opcode <= OP_CAL);
  assign launch  = wr_hs & cmd_hit & cmd_ok;

  //==================================================
  // Write channel
  //==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_rdy <= 1'b0;
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
    end else begin
      wr_rdy <= ~wr_rdy & ~bvalid & awvalid & wvalid; // One-cycle pulse, none while B pends
      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp  <= (cmd_hit & ~cmd_ok) ? RESP_SLVERR : RESP_OKAY; // STATUS and DONE ignore writes
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      cmd_valid <= 1'b0;
    else
      cmd_valid <= launch;   // One cycle after the handshake
  end

  always_ff @(posedge clk) begin
    if (launch)
      cmd_word <= wr_cmd;    // Also read back at CMD
  end

  // Completed commands
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      done_cnt <= 16'd0;
    else if (cmd_done)
      done_cnt <= done_cnt + 16'd1;
  end

  //==================================================
  // Read channel
  //==================================================
  always_comb begin
    case (araddr)
      REG_CMD:    rd_mux = cmd_word;
      REG_STATUS: rd_mux = {31'd0, issue_busy};   // Bit 0 busy
      REG_DONE:   rd_mux = {16'd0, done_cnt};
      default:    rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= ~arready & ~rvalid & arvalid;
      if (arready & arvalid)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;    // Held until accepted
    end
  end

  always_ff @(posedge clk) begin
    if (arready & arvalid)
      rdata <= rd_mux;
  end

  assign rresp = RESP_OKAY;  // Every offset reads

endmodule

// ==== rcfg_cmd_issue.sv ====
//==================================================
// Command issuer
// Latches operands of an accepted command, fires
// one master request and waits for the master
//==================================================
`timescale 1ns/1ps

module rcfg_cmd_issue (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cmd_valid,
  input  xcvr_rcfg_pkg::rcfg_cmd_t cmd_word,
  input  logic                     ctrl_busy,
  output logic                     issue_busy,
  output logic                     cmd_done,
  output logic [9:0]               ctrl_addr,
  output logic [7:0]               ctrl_writedata,
  output logic [7:0]               ctrl_datamask,
  output logic                     ctrl_write,
  output logic                     ctrl_rmw,
  output logic                     refclk_req,
  output logic                     cgb_req,
  output logic                     cal_req,
  output logic                     refclk_sel,
  output logic                     cgb_sel,
  output logic                     cal_sel
);
  import xcvr_rcfg_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,     // Ready for a command
    S_LAUNCH,   // Request pulse on the bus to the master
    S_WAIT      // Master working
  } issue_state_e;

  issue_state_e state;
  rcfg_op_e     op;
  logic         take;

  assign op         = cmd_word.data_cmd.opcode;   // Same bits in both members
  assign take       = cmd_valid & (state == S_IDLE);
  assign issue_busy = (state != S_IDLE);

  //==================================================
  // Sequencing
  //==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= S_IDLE;
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        S_IDLE:   if (cmd_valid) state <= S_LAUNCH;
        S_LAUNCH: state <= S_WAIT;
        S_WAIT: begin
          if (!ctrl_busy) begin  // Master back to idle
            state    <= S_IDLE;
            cmd_done <= 1'b1;
          end
        end
        default:  state <= S_IDLE;
      endcase
    end
  end

  // Exactly one request per command
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_write <= 1'b0;
      ctrl_rmw   <= 1'b0;
      refclk_req <= 1'b0;
      cgb_req    <= 1'b0;
      cal_req    <= 1'b0;
    end else begin
      ctrl_write <= take & (op == OP_WRITE);
      ctrl_rmw   <= take & (op == OP_RMW);
      refclk_req <= take & (op == OP_REFCLK);
      cgb_req    <= take & (op == OP_CGB);
      cal_req    <= take & (op == OP_CAL);
    end
  end

  // Operands held for the whole command
  always_ff @(posedge clk) begin
    if (take) begin
      case (op)
        OP_WRITE, OP_RMW: begin
          ctrl_addr      <= cmd_word.data_cmd.addr;
          ctrl_writedata <= cmd_word.data_cmd.wdata;
          ctrl_datamask  <= (op == OP_WRITE) ? 8'hFF : cmd_word.data_cmd.mask;
        end
        default: begin           // Logical selects
          refclk_sel <= cmd_word.sel_cmd.refclk_sel;
          cgb_sel    <= cmd_word.sel_cmd.cgb_sel;
          cal_sel    <= cmd_word.sel_cmd.cal_sel;
        end
      endcase
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_xcvr_rcfg -f src.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// ==== src.f ====
xcvr_rcfg_pkg.sv
rcfg_axil_regs.sv
rcfg_cmd_issue.sv
rcfg_avmm_mstr.sv
xcvr_rcfg_top.sv
xcvr_rcfg_props.sv
tb_xcvr_rcfg.sv

// ==== tb_xcvr_rcfg.sv ====
//==================================================
// Testbench for the reconfiguration engine
// AXI4-Lite host tasks, DPRIO register model with
// random wait requests, reference and compare
//==================================================
`timescale 1ns/1ps

module tb_xcvr_rcfg;
  import xcvr_rcfg_pkg::*;

  localparam int TIMEOUT = 200;    // Cycles per wait loop

  logic        clk, reset;
  logic [3:0]  awaddr, araddr;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [1:0]  bresp, rresp;
  logic [31:0] rdata;
  logic        xcvr_rcfg_write, xcvr_rcfg_read, xcvr_rcfg_wtrqst;
  logic [9:0]  xcvr_rcfg_address;
  logic [7:0]  xcvr_rcfg_wrdata, xcvr_rcfg_rddata;

  logic [7:0]  mem [1024];         // Lane register space
  logic [7:0]  pre_mem [1024];     // Snapshot before a command
  logic [9:0]  log_addr [$];       // Completed DPRIO writes
  logic [7:0]  log_data [$];
  int          rd_count = 0;       // Completed DPRIO reads
  logic [31:0] lfsr_state = 32'he1c03737;
  logic        hold_wtrqst;        // Stall the lane on demand
  int          burst;
  int          errors = 0;
  int          checks = 0;
  logic [15:0] exp_done = 16'd0;
  logic [9:0]  exp_addr;
  logic [7:0]  exp_data;
  int          exp_writes;
  int          exp_reads;
  logic        check_req = 1'b0;

  xcvr_rcfg_top uut (.*);

  //==================================================
  // Random source
  //==================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = 32'd0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //==================================================
  // DPRIO register model
  //==================================================
  assign xcvr_rcfg_rddata = mem[xcvr_rcfg_address];

  always @(posedge clk) begin
    if (!reset && xcvr_rcfg_write && !xcvr_rcfg_wtrqst) begin
      mem[xcvr_rcfg_address] <= xcvr_rcfg_wrdata;
      log_addr.push_back(xcvr_rcfg_address);
      log_data.push_back(xcvr_rcfg_wrdata);
    end
    if (!reset && xcvr_rcfg_read && !xcvr_rcfg_wtrqst)
      rd_count++;                              // Read data taken this cycle
    #1;
    if (hold_wtrqst) xcvr_rcfg_wtrqst = 1'b1;
    else if (burst > 0) begin
      xcvr_rcfg_wtrqst = 1'b1;
      burst--;
    end else if (take_bits(2) == 32'd0) begin   // About one in four
      xcvr_rcfg_wtrqst = 1'b1;
      burst = int'(take_bits(2)) % 3;          // Up to 3 cycles in all
    end else xcvr_rcfg_wtrqst = 1'b0;
  end

  //==================================================
  // Checking
  //==================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Run ended with %0d errors in %0d checks", errors, checks);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  // Expected {address, byte} of the single DPRIO write
  function automatic logic [17:0] ref_result(input rcfg_cmd_t c);
    logic [7:0] old;
    logic [3:0] h;
    case (c.data_cmd.opcode)
      OP_WRITE: return {c.data_cmd.addr, c.data_cmd.wdata};
      OP_RMW: begin
        old = pre_mem[c.data_cmd.addr];
        for (int i = 0; i < 8; i++)
          if (c.data_cmd.mask[i])
            old[i] = c.data_cmd.wdata[i];       // Set mask bit takes new data
        return {c.data_cmd.addr, old};
      end
      OP_REFCLK: begin
        old = c.sel_cmd.refclk_sel ? pre_mem[10'h16B] : pre_mem[10'h16A];
        return {10'h141, old};
      end
      OP_CGB: begin
        old = pre_mem[10'h117];
        h = c.sel_cmd.cgb_sel ? old[7:4] : old[3:0];
        return {10'h111, ~h[3], h[1:0], h[3], h};
      end
      default: return c.sel_cmd.cal_sel ? {10'h100, 8'hA6} : {10'h000, 8'h01};
    endcase
  endfunction

  // Compare process, run once per finished command
  always @(posedge clk) begin
    int bad;
    logic [7:0] want;
    if (check_req) begin
      bad = 0;
      check_value("dprio_write_count", 32'(log_addr.size()), 32'(exp_writes));
      check_value("dprio_read_count", 32'(rd_count), 32'(exp_reads));
      if (exp_writes == 1 && log_addr.size() == 1) begin
        check_value("xcvr_rcfg_address", 32'(log_addr[0]), 32'(exp_addr));
        check_value("xcvr_rcfg_wrdata", 32'(log_data[0]), 32'(exp_data));
      end
      for (int i = 0; i < 1024; i++) begin
        want = (exp_writes == 1 && i == int'(exp_addr)) ? exp_data : pre_mem[i];
        if (mem[i] !== want) bad++;
      end
      check_value("mem_mismatch_count", 32'(bad), 32'd0);
      check_req = 1'b0;
    end
  end

  //==================================================
  // AXI4-Lite host tasks
  //==================================================
  task automatic axil_write(input logic [3:0] a, input logic [31:0] d,
                            input logic [3:0] s, output logic [1:0] resp);
    int t;
    int dly;
    awaddr = a;
    wdata  = d;
    wstrb  = s;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      if (++t > TIMEOUT) timed_out("awready");
    end while (!awready);
    check_value("wready", 32'(wready), 32'h1);   // Pulses with awready
    #1 awvalid = 1'b0;
    wvalid = 1'b0;
    dly = int'(take_bits(2));        // Random back-pressure on B
    repeat (dly) @(posedge clk);
    #1 bready = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      if (++t > TIMEOUT) timed_out("bvalid");
    end while (!bvalid);
    resp = bresp;
    #1 bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] a, output logic [31:0] d);
    int t;
    int dly;
    araddr  = a;
    arvalid = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      if (++t > TIMEOUT) timed_out("arready");
    end while (!arready);
    #1 arvalid = 1'b0;
    dly = int'(take_bits(2));
    repeat (dly) @(posedge clk);
    #1 rready = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      if (++t > TIMEOUT) timed_out("rvalid");
    end while (!rvalid);
    d = rdata;
    check_value("rresp", 32'(rresp), 32'h0);     // Every offset reads OKAY
    #1 rready = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int t;
    t = 0;
    do begin
      axil_read(REG_STATUS, st);
      if (++t > TIMEOUT) timed_out("STATUS busy to clear");
    end while (st[0]);
  endtask

  //==================================================
  // Command sequencing
  //==================================================
  task automatic launch_cmd(input rcfg_cmd_t c);
    logic [1:0] resp;
    logic [17:0] r;
    pre_mem = mem;
    log_addr.delete();
    log_data.delete();
    rd_count = 0;
    r = ref_result(c);
    exp_addr = r[17:8];
    exp_data = r[7:0];
    exp_writes = 1;
    exp_reads  = (c.data_cmd.opcode inside {OP_RMW, OP_REFCLK, OP_CGB}) ? 1 : 0; // Read first
    axil_write(REG_CMD, c, 4'hF, resp);
    check_value("bresp", 32'(resp), 32'h0);
  endtask

  task automatic finish_cmd();
    logic [31:0] d;
    int t;
    wait_idle();
    axil_read(REG_DONE, d);
    check_value("done_count", d, {16'd0, exp_done});
    check_req = 1'b1;
    t = 0;
    while (check_req) begin
      @(posedge clk);
      if (++t > TIMEOUT) timed_out("the compare process");
    end
  endtask

  task automatic run_cmd(input rcfg_cmd_t c);
    launch_cmd(c);
    exp_done++;
    finish_cmd();
  endtask

  function automatic rcfg_cmd_t make_data(input rcfg_op_e op, input logic [9:0] a,
                                          input logic [7:0] d, input logic [7:0] m);
    rcfg_cmd_t c;
    c = '0;
    c.data_cmd.opcode = op;
    c.data_cmd.addr   = a;
    c.data_cmd.wdata  = d;
    c.data_cmd.mask   = m;
    return c;
  endfunction

  function automatic rcfg_cmd_t make_sel(input rcfg_op_e op, input logic sel);
    rcfg_cmd_t c;
    c = '0;
    c.sel_cmd.opcode     = op;
    c.sel_cmd.refclk_sel = sel;
    c.sel_cmd.cgb_sel    = sel;
    c.sel_cmd.cal_sel    = sel;
    return c;
  endfunction

  initial begin
    logic [1:0]  resp;
    awaddr  = 4'h0;
    awvalid = 1'b0;
    wdata   = 32'd0;
    wstrb   = 4'h0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = 4'h0;
    arvalid = 1'b0;
    rready  = 1'b0;
    xcvr_rcfg_wtrqst = 1'b0;
    hold_wtrqst = 1'b0;
    burst = 0;
    for (int i = 0; i < 1024; i++) mem[i] = 8'(take_bits(8));
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;

    for (int n = 0; n < 8; n++)
      run_cmd(make_data(OP_WRITE, 10'(take_bits(10)), 8'(take_bits(8)), 8'h00));
    for (int n = 0; n < 8; n++)
      run_cmd(make_data(OP_RMW, 10'(take_bits(10)), 8'(take_bits(8)), 8'(take_bits(8))));
    run_cmd(make_data(OP_WRITE, ADDR_REFCLK0_SCR, 8'h5A, 8'h00));  // Scratch bytes differ
    run_cmd(make_data(OP_WRITE, ADDR_REFCLK1_SCR, 8'hA5, 8'h00));
    run_cmd(make_sel(OP_REFCLK, 1'b0));
    run_cmd(make_sel(OP_REFCLK, 1'b1));
    for (int n = 0; n < 4; n++) begin
      run_cmd(make_data(OP_WRITE, ADDR_CGB_SCR, 8'(take_bits(8)), 8'h00)); // New scratch
      run_cmd(make_sel(OP_CGB, n[0]));
    end
    run_cmd(make_sel(OP_CAL, 1'b1));
    run_cmd(make_sel(OP_CAL, 1'b0));

    // Second command while the lane is stalled
    hold_wtrqst = 1'b1;
    launch_cmd(make_data(OP_RMW, 10'(take_bits(10)), 8'(take_bits(8)), 8'(take_bits(8))));
    exp_done++;
    axil_write(REG_CMD, make_data(OP_WRITE, 10'h3FF, 8'h55, 8'h00), 4'hF, resp);
    check_value("bresp", 32'(resp), 32'h2);
    hold_wtrqst = 1'b0;
    finish_cmd();

    // Illegal opcode
    pre_mem = mem;
    log_addr.delete();
    log_data.delete();
    rd_count = 0;
    exp_writes = 0;
    exp_reads  = 0;
    axil_write(REG_CMD, 32'hA000_0000, 4'hF, resp);
    check_value("bresp", 32'(resp), 32'h2);
    finish_cmd();

    finish_run();
  end

endmodule

// ==== xcvr_rcfg_pkg.sv ====
//==================================================
// Transceiver reconfiguration shared definitions
// DPRIO register map, calibration words, command
// opcodes, host register offsets and command word
//==================================================
package xcvr_rcfg_pkg;

  //==================================================
  // DPRIO register map of the hard transceiver
  //==================================================
  localparam logic [9:0] ADDR_REFCLK0_SCR = 10'h16A; // Refclk scratch byte 0
  localparam logic [9:0] ADDR_REFCLK1_SCR = 10'h16B; // Refclk scratch byte 1
  localparam logic [9:0] ADDR_CGB_SCR     = 10'h117; // CGB scratch, one nibble per PLL
  localparam logic [9:0] ADDR_REFCLK_MUX  = 10'h141; // Refclk mux select
  localparam logic [9:0] ADDR_CGB_MUX     = 10'h111; // CGB mux select
  localparam logic [9:0] ADDR_CAL_REQ     = 10'h100; // Calibration request
  localparam logic [9:0] ADDR_ARB         = 10'h000; // Bus arbitration

  // DCD in bit 7, VOD in bit 5, DFE in bit 2, RO in bit 1
  localparam logic [7:0] CAL_REQ_WORD     = 8'hA6;
  localparam logic [7:0] ARB_RELEASE_WORD = 8'h01;   // Hands the bus to the cal CPU

  // Command opcodes, codes 5 to 7 are refused
  typedef enum logic [2:0] {
    OP_WRITE  = 3'd0,   // Full byte write
    OP_RMW    = 3'd1,   // Masked read-modify-write
    OP_REFCLK = 3'd2,   // Logical refclk select
    OP_CGB    = 3'd3,   // Logical PLL select
    OP_CAL    = 3'd4    // Calibration handover
  } rcfg_op_e;

  // Host register byte offsets
  localparam logic [3:0] REG_CMD    = 4'h0;
  localparam logic [3:0] REG_STATUS = 4'h4;
  localparam logic [3:0] REG_DONE   = 4'h8;

  //==================================================
  // Command word, decoded by opcode in bits 31:29
  //==================================================
  typedef struct packed {
    rcfg_op_e   opcode;
    logic [2:0] pad;
    logic [9:0] addr;     // DPRIO target
    logic [7:0] wdata;
    logic [7:0] mask;     // 1 takes wdata bit, RMW only
  } rcfg_data_cmd_t;

  typedef struct packed {
    rcfg_op_e    opcode;
    logic [25:0] pad;
    logic        refclk_sel;  // Scratch byte 0 or 1
    logic        cgb_sel;     // Low or high nibble
    logic        cal_sel;     // 1 requests cal, 0 releases bus
  } rcfg_sel_cmd_t;

  typedef union packed {
    rcfg_data_cmd_t data_cmd;
    rcfg_sel_cmd_t  sel_cmd;
  } rcfg_cmd_t;

endpackage

// ==== xcvr_rcfg_props.sv ====
//==================================================
// DPRIO bus protocol checks
// Bound to the master, watches read, write and
// wait request handling
//==================================================
`timescale 1ns/1ps

module xcvr_rcfg_props (
  input logic       clk,
  input logic       reset,
  input logic       read,
  input logic       write,
  input logic       wtrqst,
  input logic [9:0] address,
  input logic [7:0] wrdata
);

  // One transfer type at a time
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(read && write))
    else $error("DPRIO read and write high together");

  // Stalled request keeps everything frozen
  a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
    (read || write) && wtrqst |=>
      $stable(read) && $stable(write) && $stable(address) && $stable(wrdata))
    else $error("DPRIO request changed under wait request");

  // First cycle out of reset, no request from the issuer yet
  a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |=> !read && !write)
    else $error("DPRIO request active right after reset");

endmodule

bind rcfg_avmm_mstr xcvr_rcfg_props u_props (
  .clk     (clk),
  .reset   (reset),
  .read    (xcvr_rcfg_read),
  .write   (xcvr_rcfg_write),
  .wtrqst  (xcvr_rcfg_wtrqst),
  .address (xcvr_rcfg_address),
  .wrdata  (xcvr_rcfg_wrdata)
);

// ==== xcvr_rcfg_top.sv ====
//==================================================
// Transceiver reconfiguration engine top level
// AXI4-Lite host port in, DPRIO lane port out
//==================================================
`timescale 1ns/1ps

module xcvr_rcfg_top (
  input  logic        clk,
  input  logic        reset,
  // AXI4-Lite host
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic        bvalid,
  output logic [1:0]  bresp,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        rready,
  // DPRIO lane
  output logic        xcvr_rcfg_write,
  output logic        xcvr_rcfg_read,
  output logic [9:0]  xcvr_rcfg_address,
  output logic [7:0]  xcvr_rcfg_wrdata,
  input  logic [7:0]  xcvr_rcfg_rddata,
  input  logic        xcvr_rcfg_wtrqst
);
  import xcvr_rcfg_pkg::*;

  // Register block to issuer
  logic      cmd_valid;
  rcfg_cmd_t cmd_word;
  logic      issue_busy;
  logic      cmd_done;

  // Issuer to master
  logic [9:0] ctrl_addr;
  logic [7:0] ctrl_writedata;
  logic [7:0] ctrl_datamask;
  logic       ctrl_write, ctrl_rmw;
  logic       refclk_req, cgb_req, cal_req;
  logic       refclk_sel, cgb_sel, cal_sel;
  logic       ctrl_busy;

  rcfg_axil_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bresp      (bresp),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rresp      (rresp),
    .rready     (rready),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .issue_busy (issue_busy),
    .cmd_done   (cmd_done)
  );

  rcfg_cmd_issue u_issue (
    .clk            (clk),
    .reset          (reset),
    .cmd_valid      (cmd_valid),
    .cmd_word       (cmd_word),
    .ctrl_busy      (ctrl_busy),
    .issue_busy     (issue_busy),
    .cmd_done       (cmd_done),
    .ctrl_addr      (ctrl_addr),
    .ctrl_writedata (ctrl_writedata),
    .ctrl_datamask  (ctrl_datamask),
    .ctrl_write     (ctrl_write),
    .ctrl_rmw       (ctrl_rmw),
    .refclk_req     (refclk_req),
    .cgb_req        (cgb_req),
    .cal_req        (cal_req),
    .refclk_sel     (refclk_sel),
    .cgb_sel        (cgb_sel),
    .cal_sel        (cal_sel)
  );

  rcfg_avmm_mstr u_mstr (
    .clk               (clk),
    .reset             (reset),
    .ctrl_addr         (ctrl_addr),
    .ctrl_writedata    (ctrl_writedata),
    .ctrl_datamask     (ctrl_datamask),
    .ctrl_write        (ctrl_write),
    .ctrl_rmw          (ctrl_rmw),
    .refclk_req        (refclk_req),
    .cgb_req           (cgb_req),
    .cal_req           (cal_req),
    .refclk_sel        (refclk_sel),
    .cgb_sel           (cgb_sel),
    .cal_sel           (cal_sel),
    .ctrl_busy         (ctrl_busy),
    .xcvr_rcfg_write   (xcvr_rcfg_write),
    .xcvr_rcfg_read    (xcvr_rcfg_read),
    .xcvr_rcfg_address (xcvr_rcfg_address),
    .xcvr_rcfg_wrdata  (xcvr_rcfg_wrdata),
    .xcvr_rcfg_rddata  (xcvr_rcfg_rddata),
    .xcvr_rcfg_wtrqst  (xcvr_rcfg_wtrqst)
  );

endmodule
